//--- bp_pkg.sv
`default_nettype none

package bp_pkg;

  localparam int addr_width = 32;
  localparam int blt_size = 32;
  localparam int blt_index_width = $clog2(blt_size);

  localparam logic [addr_width-1:0] reset_pc = 32'h0000_1000; // first fetch address.
  localparam logic [addr_width-1:0] pc_step = 32'd4;

  // two-bit saturating branch counter.
  typedef enum logic [1:0] {
    strong_not_taken = 2'b00,
    weak_not_taken   = 2'b01,
    weak_taken       = 2'b10,
    strong_taken     = 2'b11
  } counter_t;

  function automatic logic predicts_taken(counter_t state);
    return (state == weak_taken) || (state == strong_taken);
  endfunction

endpackage

`default_nettype wire

//--- match_encoder.sv
`default_nettype none
`timescale 1ns/1ns

module match_encoder #(
  parameter int width = bp_pkg::blt_size
) (
  input  logic [width-1:0]                  match,
  output logic [bp_pkg::blt_index_width-1:0] index
);

  import bp_pkg::*;

  logic [blt_index_width-1:0] position;

  // or of all set positions, exact as long as match is one-hot.
  always_comb begin
    position = '0;
    for (int i = 0; i < width; i++) begin
      if (match[i]) begin
        position = position | blt_index_width'(i);
      end
    end
  end

  assign index = position;

  // keys in the table are unique, so two matches mean the table is corrupt.
  always_comb begin
    assert ($onehot0(match))
      else $error("match_encoder: match %b has more than one bit set", match);
  end

endmodule

`default_nettype wire

//--- blt.sv
`default_nettype none
`timescale 1ns/1ns

module blt (
  input  logic                          clk,
  input  logic                          reset,

  input  logic                          write,
  input  logic [bp_pkg::addr_width-1:0] write_key,
  input  logic [bp_pkg::addr_width-1:0] write_val,
  input  logic                          hit,

  input  logic [bp_pkg::addr_width-1:0] read_key,
  output logic [bp_pkg::addr_width-1:0] read_val,
  output logic                          read_valid
);

  import bp_pkg::*;

  localparam logic [blt_index_width-1:0] last_index = blt_index_width'(blt_size - 1);

  // key = branch pc, val = branch target.
  logic [addr_width-1:0] keys [blt_size];
  logic [addr_width-1:0] vals [blt_size];
  counter_t              counters [blt_size];
  logic [blt_size-1:0]   valid;

  logic [blt_index_width-1:0] ptr; // round-robin replacement slot.
  logic [blt_index_width-1:0] ptr_next;

  logic [blt_size-1:0]        read_match;
  logic [blt_index_width-1:0] read_index;
  logic [blt_size-1:0]        write_match;
  logic [blt_index_width-1:0] write_index;
  logic                       write_known;

  function automatic counter_t step_counter(counter_t state, logic taken);
    if (taken) begin
      return (state == strong_taken) ? strong_taken : counter_t'(state + 2'd1);
    end
    return (state == strong_not_taken) ? strong_not_taken : counter_t'(state - 2'd1);
  endfunction

  always_comb begin
    for (int j = 0; j < blt_size; j++) begin
      read_match[j] = valid[j] && (keys[j] == read_key) && predicts_taken(counters[j]);
      write_match[j] = valid[j] && (keys[j] == write_key);
    end
  end

  match_encoder #(
    .width (blt_size)
  ) u_read_encoder (
    .match (read_match),
    .index (read_index)
  );

  match_encoder #(
    .width (blt_size)
  ) u_write_encoder (
    .match (write_match),
    .index (write_index)
  );

  assign read_val = vals[read_index];
  assign read_valid = |read_match;

  assign write_known = |write_match;
  assign ptr_next = (ptr == last_index) ? '0 : ptr + 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < blt_size; i++) begin
        keys[i] <= '0;
        counters[i] <= strong_not_taken;
      end
      valid <= '0;
      ptr <= '0;
    end else if (write) begin
      if (write_known) begin
        counters[write_index] <= step_counter(counters[write_index], hit);
      end else begin
        keys[ptr] <= write_key; // allocate a new entry.
        counters[ptr] <= hit ? strong_taken : strong_not_taken;
        valid[ptr] <= 1'b1;
        ptr <= ptr_next;
      end
    end
  end

  // targets.
  always_ff @(posedge clk) begin
    if (write) begin
      if (write_known) begin
        if (hit) begin
          vals[write_index] <= write_val; // keep old target on not taken.
        end
      end else begin
        vals[ptr] <= write_val;
      end
    end
  end

  // an update may only ever refer to one existing entry.
  write_single_match: assert property (
    @(posedge clk) disable iff (reset)
    write |-> $onehot0(write_match)
  ) else $error("blt: write key %h matches more than one entry", write_key);

endmodule

`default_nettype wire

//--- update_port.sv
`default_nettype none
`timescale 1ns/1ns

module update_port (
  input  logic                          clk,
  input  logic                          reset,

  input  logic                          update_req,
  input  logic [bp_pkg::addr_width-1:0] update_pc,
  input  logic [bp_pkg::addr_width-1:0] update_target,
  input  logic                          update_taken,
  output logic                          update_ack,

  output logic                          write,
  output logic [bp_pkg::addr_width-1:0] write_key,
  output logic [bp_pkg::addr_width-1:0] write_val,
  output logic                          hit
);

  import bp_pkg::*;

  typedef enum logic {
    idle,
    acked
  } state_t;

  state_t state;

  // handshake fsm.
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      write <= 1'b0;
    end else begin
      write <= 1'b0;
      case (state)
        idle: begin
          if (update_req) begin
            state <= acked;
            write <= 1'b1; // one table write per request.
          end
        end
        acked: begin
          if (!update_req) state <= idle; // ack drops with req.
        end
        default: state <= idle;
      endcase
    end
  end

  // request fields, taken at acceptance.
  always_ff @(posedge clk) begin
    if (state == idle && update_req) begin
      write_key <= update_pc;
      write_val <= update_target;
      hit <= update_taken;
    end
  end

  assign update_ack = (state == acked);

  write_single_pulse: assert property (
    @(posedge clk) disable iff (reset)
    write |=> !write
  ) else $error("update_port: write held for two cycles");

endmodule

`default_nettype wire

//--- next_pc.sv
`default_nettype none
`timescale 1ns/1ns

module next_pc (
  input  logic                          clk,
  input  logic                          reset,

  input  logic                          fetch_ready,
  input  logic                          redirect,
  input  logic [bp_pkg::addr_width-1:0] redirect_pc,

  input  logic [bp_pkg::addr_width-1:0] read_val,
  input  logic                          read_valid,

  output logic [bp_pkg::addr_width-1:0] fetch_pc
);

  import bp_pkg::*;

  logic [addr_width-1:0] sequential_pc;

  assign sequential_pc = fetch_pc + pc_step;

  // redirect first, then prediction, then fall through.
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_pc <= reset_pc;
    end else if (redirect) begin
      fetch_pc <= redirect_pc; // applies even under back-pressure.
    end else if (fetch_ready) begin
      fetch_pc <= read_valid ? read_val : sequential_pc;
    end
  end

  // a stalled front end must not lose its place.
  pc_hold_on_stall: assert property (
    @(posedge clk) disable iff (reset)
    (!fetch_ready && !redirect) |=> $stable(fetch_pc)
  ) else $error("next_pc: fetch_pc moved while stalled");

endmodule

`default_nettype wire

//--- branch_predictor.sv
`default_nettype none
`timescale 1ns/1ns

module branch_predictor (
  input  logic                          clk,
  input  logic                          reset,

  // fetch side.
  input  logic                          fetch_ready,
  input  logic                          redirect,
  input  logic [bp_pkg::addr_width-1:0] redirect_pc,
  output logic [bp_pkg::addr_width-1:0] fetch_pc,
  output logic                          predict_taken,

  // resolved branches from execute.
  input  logic                          update_req,
  input  logic [bp_pkg::addr_width-1:0] update_pc,
  input  logic [bp_pkg::addr_width-1:0] update_target,
  input  logic                          update_taken,
  output logic                          update_ack
);

  import bp_pkg::*;

  logic                  write;
  logic [addr_width-1:0] write_key;
  logic [addr_width-1:0] write_val;
  logic                  hit;
  logic [addr_width-1:0] read_val;

  update_port u_update_port (
    .clk           (clk),
    .reset         (reset),
    .update_req    (update_req),
    .update_pc     (update_pc),
    .update_target (update_target),
    .update_taken  (update_taken),
    .update_ack    (update_ack),
    .write         (write),
    .write_key     (write_key),
    .write_val     (write_val),
    .hit           (hit)
  );

  blt u_blt (
    .clk        (clk),
    .reset      (reset),
    .write      (write),
    .write_key  (write_key),
    .write_val  (write_val),
    .hit        (hit),
    .read_key   (fetch_pc),
    .read_val   (read_val),
    .read_valid (predict_taken) // a valid read is the prediction.
  );

  next_pc u_next_pc (
    .clk         (clk),
    .reset       (reset),
    .fetch_ready (fetch_ready),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .read_val    (read_val),
    .read_valid  (predict_taken),
    .fetch_pc    (fetch_pc)
  );

endmodule

`default_nettype wire

//--- tb_clock.sv
`default_nettype none
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic reset
);

  localparam int half_period = 2; // 4 ns clock.

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // reset held for four rising edges, released just after the last.
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- tb_branch_predictor.sv
`default_nettype none
`timescale 1ns/1ns

module tb_branch_predictor;

  import bp_pkg::*;

  localparam int wait_limit = 20;

  logic clk;
  logic reset;
  logic fetch_ready;
  logic redirect;
  logic [addr_width-1:0] redirect_pc;
  logic [addr_width-1:0] fetch_pc;
  logic predict_taken;
  logic update_req;
  logic [addr_width-1:0] update_pc;
  logic [addr_width-1:0] update_target;
  logic update_taken;
  logic update_ack;

  // reference model of the table and the fetch pc.
  logic [addr_width-1:0] model_key [blt_size];
  logic [addr_width-1:0] model_val [blt_size];
  logic [1:0]            model_cnt [blt_size];
  logic [blt_size-1:0]   model_valid;
  int                    model_ptr;
  logic [addr_width-1:0] exp_pc;
  logic                  model_hit;
  logic [addr_width-1:0] model_target;

  // accepted request waiting to reach the model.
  logic [addr_width-1:0] pend_pc;
  logic [addr_width-1:0] pend_target;
  logic                  pend_taken;
  int accepted = 0;
  int applied;

  int seed = 32'hebd8;
  int fetch_errs = 0;
  int predict_errs = 0;
  int rise_errs = 0;
  int fall_errs = 0;
  int reset_errs = 0;
  int direct_errs = 0;
  int timeouts = 0;

  tb_clock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  branch_predictor u_branch_predictor (
    .clk           (clk),
    .reset         (reset),
    .fetch_ready   (fetch_ready),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .fetch_pc      (fetch_pc),
    .predict_taken (predict_taken),
    .update_req    (update_req),
    .update_pc     (update_pc),
    .update_target (update_target),
    .update_taken  (update_taken),
    .update_ack    (update_ack)
  );

  always_comb begin
    model_hit = 1'b0;
    model_target = '0;
    for (int i = 0; i < blt_size; i++) begin
      if (model_valid[i] && model_key[i] == exp_pc &&
          (model_cnt[i] == weak_taken || model_cnt[i] == strong_taken)) begin
        model_hit = 1'b1;
        model_target = model_val[i];
      end
    end
  end

  always @(posedge clk) begin : model_write
    int slot;
    slot = -1;
    if (reset) begin
      for (int i = 0; i < blt_size; i++) begin
        model_key[i] <= '0;
        model_cnt[i] <= strong_not_taken;
      end
      model_valid <= '0;
      model_ptr <= 0;
      applied <= 0;
    end else if (applied != accepted) begin
      for (int i = 0; i < blt_size; i++) begin
        if (model_valid[i] && model_key[i] == pend_pc) slot = i;
      end
      if (slot >= 0) begin
        if (pend_taken) begin
          model_cnt[slot] <= (model_cnt[slot] == strong_taken) ? 2'd3 : model_cnt[slot] + 2'd1;
          model_val[slot] <= pend_target;
        end else begin
          model_cnt[slot] <= (model_cnt[slot] == strong_not_taken) ? 2'd0 : model_cnt[slot] - 2'd1;
        end
      end else begin
        model_key[model_ptr] <= pend_pc; // new entry at the round-robin slot.
        model_val[model_ptr] <= pend_target;
        model_cnt[model_ptr] <= pend_taken ? strong_taken : strong_not_taken;
        model_valid[model_ptr] <= 1'b1;
        model_ptr <= (model_ptr == blt_size - 1) ? 0 : model_ptr + 1;
      end
      applied <= accepted;
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      exp_pc <= reset_pc;
    end else if (redirect) begin
      exp_pc <= redirect_pc;
    end else if (fetch_ready) begin
      exp_pc <= model_hit ? model_target : exp_pc + pc_step;
    end
  end

  fetch_pc_check: assert property (@(posedge clk) disable iff (reset) fetch_pc == exp_pc)
    else begin
      fetch_errs++;
      $display("ERR fetch_pc got %h exp %h", $sampled(fetch_pc), $sampled(exp_pc));
    end

  predict_check: assert property (@(posedge clk) disable iff (reset) predict_taken == model_hit)
    else begin
      predict_errs++;
      $display("ERR predict_taken got %h exp %h", $sampled(predict_taken), $sampled(model_hit));
    end

  ack_rise_check: assert property (
    @(posedge clk) disable iff (reset) $rose(update_ack) |-> $past(update_req)
  ) else begin
    rise_errs++;
    $display("update_ack rose without a pending update_req");
  end

  ack_fall_check: assert property (
    @(posedge clk) disable iff (reset) $fell(update_ack) |-> !$past(update_req)
  ) else begin
    fall_errs++;
    $display("update_ack fell while update_req was still high");
  end

  // first edge out of reset.
  reset_state_check: assert property (
    @(posedge clk) $fell(reset) |-> (fetch_pc == reset_pc && !predict_taken && !update_ack)
  ) else begin
    reset_errs++;
    $display("outputs not in their reset state after reset was released");
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic expect_pc(input logic [addr_width-1:0] exp);
    assert (fetch_pc == exp)
      else begin
        direct_errs++;
        $display("ERR fetch_pc got %h exp %h", fetch_pc, exp);
      end
  endtask

  task automatic expect_predict(input logic exp);
    assert (predict_taken == exp)
      else begin
        direct_errs++;
        $display("ERR predict_taken got %h exp %h", predict_taken, exp);
      end
  endtask

  task automatic redirect_to(input logic [addr_width-1:0] pc);
    redirect = 1'b1;
    redirect_pc = pc;
    step();
    redirect = 1'b0;
  endtask

  // execute stage side of the four-phase handshake.
  task automatic do_update(input logic [addr_width-1:0] pc, input logic [addr_width-1:0] target,
                           input logic taken);
    int n;
    update_pc = pc;
    update_target = target;
    update_taken = taken;
    update_req = 1'b1;
    n = 0;
    do begin
      step();
      n++;
    end while (!update_ack && n < wait_limit);
    if (update_ack) begin
      pend_pc = pc;
      pend_target = target;
      pend_taken = taken;
      accepted++;
    end else begin
      timeouts++;
      $display("timeout waiting for update_ack to rise, pc %h", pc);
    end
    update_req = 1'b0;
    n = 0;
    do begin
      step();
      n++;
    end while (update_ack && n < wait_limit);
    if (update_ack) begin
      timeouts++;
      $display("timeout waiting for update_ack to fall, pc %h", pc);
    end
    step();
    step();
  endtask

  function automatic logic [addr_width-1:0] random_word();
    return $random(seed) & 32'hffff_fffc;
  endfunction

  initial begin
    logic [addr_width-1:0] pc_x;
    logic [addr_width-1:0] pc_y;
    logic [addr_width-1:0] tgt;
    logic [addr_width-1:0] tgt2;
    logic [addr_width-1:0] base;
    logic [addr_width-1:0] pc;
    int n;
    int total;

    fetch_ready = 1'b0;
    redirect = 1'b0;
    redirect_pc = '0;
    update_req = 1'b0;
    update_pc = '0;
    update_target = '0;
    update_taken = 1'b0;

    // reset is sampled at the edge, away from its own release.
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (reset !== 1'b0 && n < wait_limit);
    if (reset !== 1'b0) begin
      timeouts++;
      $display("timeout waiting for reset to be released");
    end
    #1;

    // sequential fetch and stall.
    repeat (3) step();
    fetch_ready = 1'b1;
    repeat (6) step();
    fetch_ready = 1'b0;
    repeat (3) step();
    fetch_ready = 1'b1;

    pc_x = 32'h2000_0000 | (random_word() & 32'h00ff_fffc);
    pc_y = 32'h3000_0000 | (random_word() & 32'h00ff_fffc);
    tgt = random_word();
    tgt2 = random_word();

    do_update(pc_x, tgt, 1'b1);
    redirect_to(pc_x);
    expect_predict(1'b1);
    step();
    expect_pc(tgt);
    do_update(pc_y, random_word(), 1'b0);
    redirect_to(pc_y);
    expect_predict(1'b0);

    // counter walks down from strong_taken and back up.
    do_update(pc_x, tgt2, 1'b0);
    redirect_to(pc_x);
    expect_predict(1'b1);
    step();
    expect_pc(tgt); // old target kept on not taken.
    do_update(pc_x, tgt2, 1'b0);
    redirect_to(pc_x);
    expect_predict(1'b0);
    do_update(pc_x, tgt2, 1'b0);
    do_update(pc_x, tgt2, 1'b1);
    redirect_to(pc_x);
    expect_predict(1'b0);
    do_update(pc_x, tgt2, 1'b1);
    redirect_to(pc_x);
    expect_predict(1'b1);
    step();
    expect_pc(tgt2);

    // one more distinct branch than the table holds.
    base = 32'h4000_0000 | (random_word() & 32'h00ff_0000);
    for (int i = 0; i <= blt_size; i++) begin
      do_update(base + 32'(i * 16), random_word(), 1'b1);
    end
    for (int i = 0; i <= blt_size; i++) begin
      redirect_to(base + 32'(i * 16));
      expect_predict(i != 0);
    end

    // redirect beats a live prediction.
    redirect_to(base + 32'd16);
    expect_predict(1'b1);
    tgt = random_word();
    redirect_to(tgt);
    expect_pc(tgt);

    for (int i = 0; i < 24; i++) begin
      pc = 32'h0800_0000 | (($random(seed) & 32'h7) << 2);
      do_update(pc, random_word(), $random(seed) & 1);
      redirect_to(pc);
      step();
    end
    repeat (4) step();

    total = fetch_errs + predict_errs + rise_errs + fall_errs + reset_errs + direct_errs +
            timeouts;
    $display("errors: fetch %0d predict %0d rise %0d fall %0d reset %0d direct %0d timeout %0d",
             fetch_errs, predict_errs, rise_errs, fall_errs, reset_errs, direct_errs, timeouts);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- branch_predictor.f
bp_pkg.sv
match_encoder.sv
blt.sv
update_port.sv
next_pc.sv
branch_predictor.sv
tb_clock.sv
tb_branch_predictor.sv

//--- Makefile
# Verilator build and run for the branch predictor testbench.

VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= branch_predictor.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^test passed$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
